/* design/ieu.sv */
// ********************
// Integer execution unit top level
// Decode-to-execute register, result queue, CDB request and broadcast
// ********************

`timescale 1ns/1ps

module ieu (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               i_flush,
    input  ieu_pkg::rs_issue_t i_issue,
    output logic               o_stall,
    output logic               o_arb_req,
    input  logic               i_arb_gnt,
    output ieu_pkg::cdb_pkt_t  o_cdb
);

    import ieu_pkg::*;

    id_ex_t   dec;
    id_ex_t   dec_q;
    id_ex_t   ex_in;
    logic     dec_valid_q;
    logic     accept;
    cdb_pkt_t ex_result;
    cdb_pkt_t fifo_head;

    ieu_id ieu_id_i (
        .i_issue (i_issue),
        .o_dec   (dec)
    );

    // Issue is taken only when the queue has room for it
    assign accept = dec.valid & ~o_stall;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            dec_valid_q <= 1'b0;
        end else if (i_flush) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        dec_q <= dec;
    end

    always_comb begin
        ex_in       = dec_q;
        ex_in.valid = dec_valid_q;
    end

    ieu_ex ieu_ex_i (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_flush  (i_flush),
        .i_dec    (ex_in),
        .o_result (ex_result)
    );

    result_fifo result_fifo_i (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_flush (i_flush),
        .i_wr    (ex_result),
        .i_rd    (i_arb_gnt),
        .o_head  (fifo_head),
        .o_stall (o_stall)
    );

    // Request the bus while anything is queued
    assign o_arb_req = fifo_head.valid;

    // Head goes out in the grant cycle and is popped at the same edge
    always_comb begin
        o_cdb       = fifo_head;
        o_cdb.valid = i_arb_gnt & fifo_head.valid;
    end

endmodule

/* design/ieu_ex.sv */
// ********************
// Execute stage of the integer execution unit
// ALU, branch compare, target address, registered result
// ********************

`timescale 1ns/1ps

module ieu_ex (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              i_flush,
    input  ieu_pkg::id_ex_t   i_dec,
    output ieu_pkg::cdb_pkt_t o_result
);

    import ieu_pkg::*;

    data_t    op_b;
    data_t    alu_res;
    logic     eq;
    logic     lt_s;
    logic     lt_u;
    logic     taken;
    addr_t    pc_next;
    addr_t    target;
    cdb_pkt_t res_d;
    cdb_pkt_t res_q;
    logic     valid_q;

    // Branches compare against src_b, everything else uses the immediate slot
    assign op_b = i_dec.br ? i_dec.src_b : i_dec.imm;

    // Comparisons shared by SLT/SLTU and the branches
    assign eq   = (i_dec.src_a == op_b);
    assign lt_s = ($signed(i_dec.src_a) < $signed(op_b));
    assign lt_u = (i_dec.src_a < op_b);

    always_comb begin
        case (i_dec.alu_func)
            ALU_ADD:   alu_res = i_dec.src_a + op_b;
            ALU_SUB:   alu_res = i_dec.src_a - op_b;
            ALU_SLL:   alu_res = i_dec.src_a << i_dec.shamt;
            ALU_SLT:   alu_res = data_t'(lt_s);
            ALU_SLTU:  alu_res = data_t'(lt_u);
            ALU_XOR:   alu_res = i_dec.src_a ^ op_b;
            ALU_SRL:   alu_res = i_dec.src_a >> i_dec.shamt;
            ALU_SRA:   alu_res = data_t'($signed(i_dec.src_a) >>> i_dec.shamt);
            ALU_OR:    alu_res = i_dec.src_a | op_b;
            ALU_AND:   alu_res = i_dec.src_a & op_b;
            ALU_LUI:   alu_res = i_dec.imm;
            ALU_AUIPC: alu_res = data_t'(i_dec.iaddr) + i_dec.imm;
            default:   alu_res = '0;
        endcase
    end

    always_comb begin
        case (i_dec.alu_func)
            ALU_BEQ:  taken = eq;
            ALU_BNE:  taken = ~eq;
            ALU_BLT:  taken = lt_s;
            ALU_BGE:  taken = ~lt_s;
            ALU_BLTU: taken = lt_u;
            ALU_BGEU: taken = ~lt_u;
            default:  taken = 1'b0;
        endcase
    end

    // JALR is register relative with bit 0 dropped, the rest are pc relative
    assign pc_next = i_dec.iaddr + addr_t'(4);
    assign target  = (i_dec.alu_func == ALU_JALR) ?
                     (addr_t'(i_dec.src_a + i_dec.imm) & ~addr_t'(1)) :
                     (i_dec.iaddr + addr_t'(i_dec.imm));

    always_comb begin
        res_d.tag   = i_dec.tag;
        res_d.valid = i_dec.valid;
        if (i_dec.jmp) begin
            // Link value goes out as data
            res_d.data     = data_t'(pc_next);
            res_d.addr     = target;
            res_d.redirect = 1'b1;
        end else if (i_dec.br) begin
            res_d.data     = '0;
            res_d.addr     = taken ? target : pc_next;
            res_d.redirect = taken;
        end else begin
            res_d.data     = alu_res;
            res_d.addr     = '0;
            res_d.redirect = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= res_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        res_q <= res_d;
    end

    always_comb begin
        o_result       = res_q;
        o_result.valid = valid_q;
    end

endmodule

/* design/ieu_id.sv */
// ********************
// Instruction decoder of the integer execution unit
// Opcode/funct to ALU function, immediates, jump and branch flags
// ********************

`timescale 1ns/1ps

module ieu_id (
    input  ieu_pkg::rs_issue_t i_issue,
    output ieu_pkg::id_ex_t    o_dec
);

    import ieu_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    insn_t      insn;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    data_t      imm_i;
    data_t      imm_u;
    data_t      imm_j;
    data_t      imm_b;

    // Register and immediate arithmetic share the funct3 map
    function automatic alu_func_t arith_func(input logic [2:0] f3, input logic alt);
        unique case (f3)
            3'b000: return alt ? ALU_SUB : ALU_ADD;
            3'b001: return ALU_SLL;
            3'b010: return ALU_SLT;
            3'b011: return ALU_SLTU;
            3'b100: return ALU_XOR;
            3'b101: return alt ? ALU_SRA : ALU_SRL;
            3'b110: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic alu_func_t branch_func(input logic [2:0] f3);
        case (f3)
            3'b001: return ALU_BNE;
            3'b100: return ALU_BLT;
            3'b101: return ALU_BGE;
            3'b110: return ALU_BLTU;
            3'b111: return ALU_BGEU;
            default: return ALU_BEQ;
        endcase
    endfunction

    assign insn      = i_issue.insn;
    assign opcode    = insn[6:0];
    assign funct3    = insn[14:12];
    assign funct7_b5 = insn[30];

    // Sign-extended immediate formats
    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_u = {insn[31:12], 12'b0};
    assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

    always_comb begin
        o_dec.alu_func = ALU_ADD;
        o_dec.src_a    = i_issue.src_a;
        o_dec.src_b    = i_issue.src_b;
        o_dec.iaddr    = i_issue.iaddr;
        o_dec.imm      = '0;
        o_dec.shamt    = insn[24:20];
        o_dec.tag      = i_issue.tag;
        o_dec.jmp      = 1'b0;
        o_dec.br       = 1'b0;
        o_dec.valid    = i_issue.valid;

        case (opcode)
            OPC_OP: begin
                // Register form carries src_b in the immediate slot
                o_dec.alu_func = arith_func(funct3, funct7_b5);
                o_dec.imm      = i_issue.src_b;
                o_dec.shamt    = i_issue.src_b[4:0];
            end
            OPC_OP_IMM: begin
                // Only SRAI uses bit 30, ADDI never subtracts
                o_dec.alu_func = arith_func(funct3, funct7_b5 & (funct3 == 3'b101));
                o_dec.imm      = imm_i;
            end
            OPC_LUI: begin
                o_dec.alu_func = ALU_LUI;
                o_dec.imm      = imm_u;
            end
            OPC_AUIPC: begin
                o_dec.alu_func = ALU_AUIPC;
                o_dec.imm      = imm_u;
            end
            OPC_JAL: begin
                o_dec.alu_func = ALU_JAL;
                o_dec.imm      = imm_j;
                o_dec.jmp      = 1'b1;
            end
            OPC_JALR: begin
                o_dec.alu_func = ALU_JALR;
                o_dec.imm      = imm_i;
                o_dec.jmp      = 1'b1;
            end
            OPC_BRANCH: begin
                o_dec.alu_func = branch_func(funct3);
                o_dec.imm      = imm_b;
                o_dec.br       = 1'b1;
            end
            default: begin
                o_dec.alu_func = ALU_ADD;
            end
        endcase
    end

endmodule

/* design/ieu_params.svh */
// ********************
// Width and depth macros for the integer execution unit
// Result FIFO sizing and the in-flight reserve behind it
// ********************

`ifndef IEU_PARAMS_SVH
`define IEU_PARAMS_SVH

// Operand and result word
`define IEU_DATA_WIDTH 32

// Instruction address
`define IEU_ADDR_WIDTH 32

// Reorder buffer tag
`define IEU_TAG_WIDTH 6

// Result FIFO entries
`define IEU_FIFO_DEPTH 8

// Results that can sit in the decode-to-execute and execute registers
`define IEU_PIPE_RESERVE 2

`endif

/* design/ieu_pkg.sv */
// ********************
// Types shared by the integer execution unit
// Width typedefs, ALU function enum, stage structs
// ********************

`include "ieu_params.svh"

package ieu_pkg;

    typedef logic [`IEU_DATA_WIDTH-1:0] data_t;
    typedef logic [`IEU_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`IEU_TAG_WIDTH-1:0]  tag_t;
    typedef logic [31:0]                insn_t;
    typedef logic [4:0]                 shamt_t;

    // One entry per operation the execute stage knows
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,
        ALU_AUIPC,
        ALU_JAL,
        ALU_JALR,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU
    } alu_func_t;

    // Issue from the reservation station, operands already read
    typedef struct packed {
        insn_t insn;
        addr_t iaddr;
        data_t src_a;
        data_t src_b;
        tag_t  tag;
        logic  valid;
    } rs_issue_t;

    // Decoded instruction handed from decode to execute
    typedef struct packed {
        alu_func_t alu_func;
        data_t     src_a;
        data_t     src_b;
        addr_t     iaddr;
        data_t     imm;
        shamt_t    shamt;
        tag_t      tag;
        logic      jmp;
        logic      br;
        logic      valid;
    } id_ex_t;

    // Result entry, valid must stay the last field
    typedef struct packed {
        data_t data;
        addr_t addr;
        tag_t  tag;
        logic  redirect;
        logic  valid;
    } cdb_pkt_t;

endpackage

/* design/result_fifo.sv */
// ********************
// In-order result queue between execute and the CDB
// Circular buffer, occupancy count, reserve-based stall
// ********************

`timescale 1ns/1ps
`include "ieu_params.svh"

module result_fifo #(
    parameter int DEPTH   = `IEU_FIFO_DEPTH,
    parameter int RESERVE = `IEU_PIPE_RESERVE
) (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              i_flush,
    input  ieu_pkg::cdb_pkt_t i_wr,
    input  logic              i_rd,
    output ieu_pkg::cdb_pkt_t o_head,
    output logic              o_stall
);

    import ieu_pkg::*;

    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int ENTRY_W = $bits(cdb_pkt_t) - 1;

    // Entries hold the packet without its valid bit
    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               empty;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign rd_en = i_rd & ~empty;
    // A read in the same cycle frees the slot being written
    assign wr_en = i_wr.valid & (~full | rd_en);

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= i_wr[ENTRY_W:1];
    end

    assign o_head = {mem[rd_ptr], ~empty};

    // Leave room for everything still in the pipe behind the queue
    assign o_stall = (int'(count) + RESERVE) >= DEPTH;

endmodule

/* ieu.f */
+incdir+design
design/ieu_pkg.sv
design/ieu_id.sv
design/ieu_ex.sv
design/result_fifo.sv
design/ieu.sv
verification/ieu_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f ieu.f --top-module ieu_tb -o ieu_sim &&
./obj_dir/ieu_sim | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* verification/ieu_input.txt */
# insn iaddr src_a src_b tag exp_data exp_addr exp_redirect flush (all hex)
# flush 1 kills this line and all results still owed
003100B3 00000000 00001234 00000F0F 01 00002143 00000000 0 0
403100B3 00000004 00000005 00000007 02 FFFFFFFE 00000000 0 0
403150B3 00000008 80000000 00000024 03 F8000000 00000000 0 0
003120B3 0000000C FFFFFFFF 00000001 04 00000001 00000000 0 0
003130B3 00000010 FFFFFFFF 00000001 05 00000000 00000000 0 0
FFF10093 00000014 00000010 DEADBEEF 06 0000000F 00000000 0 0
00815093 00000018 80000000 DEADBEEF 07 00800000 00000000 0 0
40815093 0000001C 80000000 DEADBEEF 08 FF800000 00000000 0 0
0F017093 00000020 12345678 DEADBEEF 09 00000070 00000000 0 0
80016093 00000024 00000001 DEADBEEF 0A FFFFF801 00000000 0 0
003160B3 00000028 000000F0 0000000F 0B 000000FF 00000000 0 1
123450B7 0000002C DEADBEEF DEADBEEF 0C 12345000 00000000 0 0
00001097 00000100 DEADBEEF DEADBEEF 0D 00001100 00000000 0 0
020000EF 00000200 DEADBEEF DEADBEEF 0E 00000204 00000220 1 0
FF9FF0EF 00000300 DEADBEEF DEADBEEF 0F 00000304 000002F8 1 0
005100E7 00000400 00001000 DEADBEEF 10 00000404 00001004 1 0
00310863 00000500 00000005 00000005 11 00000000 00000510 1 0
00311863 00000600 00000005 00000005 12 00000000 00000604 0 0
00314863 00000700 FFFFFFFE 00000001 13 00000000 00000710 1 0
00315863 00000780 FFFFFFFE 00000001 14 00000000 00000784 0 0
00316863 00000790 FFFFFFFE 00000001 15 00000000 00000794 0 0
FE3178E3 00000800 FFFFFFFE 00000001 16 00000000 000007F0 1 0

/* verification/ieu_tb.sv */
// ********************
// Self-checking testbench for the integer execution unit
// Plays reservation station and CDB arbiter, reads vectors from a file
// ********************

`timescale 1ns/1ps
`include "ieu_params.svh"

module ieu_tb;

    import ieu_pkg::*;

    // One line of the vector file
    typedef struct packed {
        insn_t insn;
        addr_t iaddr;
        data_t src_a;
        data_t src_b;
        tag_t  tag;
        data_t data;
        addr_t addr;
        logic  redirect;
        logic  flush;
    } vec_t;

    logic      clk = 1'b0;
    logic      n_rst;
    logic      i_flush;
    rs_issue_t i_issue;
    logic      o_stall;
    logic      o_arb_req;
    logic      i_arb_gnt;
    cdb_pkt_t  o_cdb;

    vec_t        vecs[$];
    cdb_pkt_t    expq[$];
    cdb_pkt_t    want_pkt;
    logic        stale [1 << `IEU_TAG_WIDTH];
    logic        stall_s = 1'b0;
    logic        req_s = 1'b0;
    logic        hold_gnt = 1'b0;
    logic        rst_tail = 1'b0;
    logic [31:0] rnd;
    integer      seed = 32'h2901;
    int          quiet = 0;
    int          n_checks = 0;
    int          n_errors = 0;

    ieu dut_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_flush   (i_flush),
        .i_issue   (i_issue),
        .o_stall   (o_stall),
        .o_arb_req (o_arb_req),
        .i_arb_gnt (i_arb_gnt),
        .o_cdb     (o_cdb)
    );

    always #2 clk = ~clk;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [9];
        vec_t        v;
        fd = $fopen("verification/ieu_input.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("Could not open the vector file verification/ieu_input.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (n != 9) begin
                    n_errors++;
                    $display("Vector line could not be parsed: %s", line);
                end else begin
                    v.insn     = f[0];
                    v.iaddr    = f[1];
                    v.src_a    = f[2];
                    v.src_b    = f[3];
                    v.tag      = f[4][`IEU_TAG_WIDTH-1:0];
                    v.data     = f[5];
                    v.addr     = f[6];
                    v.redirect = f[7][0];
                    v.flush    = f[8][0];
                    vecs.push_back(v);
                end
            end
        end
        $fclose(fd);
    endtask

    // Called right after a rising edge, returns at the accepting edge
    task automatic issue_vector(input vec_t v);
        rs_issue_t pkt;
        cdb_pkt_t  want;
        pkt.insn      = v.insn;
        pkt.iaddr     = v.iaddr;
        pkt.src_a     = v.src_a;
        pkt.src_b     = v.src_b;
        pkt.tag       = v.tag;
        pkt.valid     = 1'b1;
        want.data     = v.data;
        want.addr     = v.addr;
        want.tag      = v.tag;
        want.redirect = v.redirect;
        want.valid    = 1'b1;
        i_issue <= pkt;
        @(posedge clk);
        while (stall_s) @(posedge clk);
        expq.push_back(want);
        stale[v.tag] = 1'b0;
    endtask

    // Kill everything in flight and mark the owed tags stale
    task automatic flush_pipe();
        cdb_pkt_t drop;
        i_issue <= '0;
        @(negedge clk);
        hold_gnt = 1'b1;
        @(posedge clk);
        i_flush <= 1'b1;
        while (expq.size() > 0) begin
            drop = expq.pop_front();
            stale[drop.tag] = 1'b1;
        end
        @(posedge clk);
        i_flush <= 1'b0;
        @(negedge clk);
        compare("o_arb_req", o_arb_req, 0);
        hold_gnt = 1'b0;
        @(posedge clk);
    endtask

    // Arbiter with random grants and long quiet stretches
    always @(posedge clk) begin
        if (!n_rst || hold_gnt) begin
            i_arb_gnt <= 1'b0;
        end else begin
            rnd = $random(seed);
            if (quiet > 0) begin
                quiet = quiet - 1;
            end else if (rnd[7:4] == 4'd0) begin
                quiet = int'(rnd[12:8]) * 2;
            end
            // Never two grants in a row, so the head is always there
            i_arb_gnt <= req_s && !i_arb_gnt && (quiet == 0) && rnd[0];
        end
    end

    // Outputs sampled mid-cycle where they are stable
    always @(negedge clk) begin
        stall_s = o_stall;
        req_s   = o_arb_req;
        if (!n_rst || rst_tail) begin
            compare("o_stall", o_stall, 0);
            compare("o_arb_req", o_arb_req, 0);
            compare("o_cdb.valid", o_cdb.valid, 0);
            rst_tail = !n_rst;
        end
        if (n_rst && !i_flush) begin
            if (expq.size() == 0) begin
                compare("o_arb_req", o_arb_req, 0);
            end else if (expq.size() > `IEU_PIPE_RESERVE) begin
                compare("o_arb_req", o_arb_req, 1);
            end
            // Owed results sit in the queue or in the two stages behind it
            if (expq.size() >= `IEU_FIFO_DEPTH) begin
                compare("o_stall", o_stall, 1);
            end else if (expq.size() < `IEU_FIFO_DEPTH - `IEU_PIPE_RESERVE) begin
                compare("o_stall", o_stall, 0);
            end
        end
        if (o_cdb.valid) begin
            if (stale[o_cdb.tag]) begin
                n_errors++;
                $display("Flushed tag %0d was broadcast at %0t", o_cdb.tag, $time);
            end
            if (expq.size() == 0) begin
                n_errors++;
                $display("Broadcast of tag %0d at %0t with no result owed", o_cdb.tag, $time);
            end else begin
                want_pkt = expq.pop_front();
                compare("o_cdb.tag", o_cdb.tag, want_pkt.tag);
                compare("o_cdb.data", o_cdb.data, want_pkt.data);
                compare("o_cdb.addr", o_cdb.addr, want_pkt.addr);
                compare("o_cdb.redirect", o_cdb.redirect, want_pkt.redirect);
            end
        end
    end

    initial begin
        n_rst     = 1'b0;
        i_flush   = 1'b0;
        i_arb_gnt = 1'b0;
        i_issue   = '0;
        foreach (stale[i]) stale[i] = 1'b0;
        load_vectors();
        repeat (16) @(posedge clk);
        n_rst <= 1'b1;
        foreach (vecs[i]) begin
            issue_vector(vecs[i]);
            if (vecs[i].flush) flush_pipe();
        end
        i_issue <= '0;
        while (expq.size() != 0) @(posedge clk);
        // A few idle cycles catch extra broadcasts
        repeat (8) @(posedge clk);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        #1;
        repeat (vecs.size() * 40 + 16) @(posedge clk);
        $display("Timeout, results still owed after %0d vectors", vecs.size());
        $display("=== FAIL ===");
        $finish;
    end

endmodule
